// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = ifetch_tb
FILELIST  = verilog.f
PASS_TEXT = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// File: common/ifu_pkg.sv
package ifu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // Memory data word, also a full long instruction
    typedef logic [31:0] word_t;

    // Word address, byte address bits 31 to 2
    typedef logic [29:0] waddr_t;

    // Halfword program counter, byte address bits 31 to 1
    typedef logic [30:0] pc_t;

    // One instruction half
    typedef logic [15:0] half_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    // Halfword fetched after reset
    localparam pc_t RESET_PC = 31'd0;

    // Low two bits of a half that marks a 32-bit instruction
    localparam logic [1:0] LONG_OPCODE = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////////////////////

    // Wishbone port, idle or running one classic read
    typedef enum logic {
        IDLE,
        BUS
    } wb_state_e;

    // Where the next instruction starts in the current word
    typedef enum logic [1:0] {
        LOW,
        HIGH,
        SPLIT
    } align_state_e;

endpackage

// File: ifetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic             stall_i,
    input  logic             branch_i,
    input  ifu_pkg::pc_t     branch_pc_i,

    input  ifu_pkg::word_t   fetch_data_i,
    input  logic             fetch_ready_i,
    output ifu_pkg::waddr_t  fetch_addr_o,

    output ifu_pkg::word_t   instr_o,
    output logic             is_long_o,
    output ifu_pkg::pc_t     pc_o,
    output logic             instr_valid_o,
    output logic             busywait_o
);

    ifu_pkg::waddr_t word_cnt;
    ifu_pkg::waddr_t word_cnt_inc;
    ifu_pkg::waddr_t pc_word;

    logic            accept_branch;
    logic            step;

    ifu_pkg::word_t  align_instr;
    logic            align_long;
    logic            align_complete;
    logic            align_word_done;
    logic            align_high;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake with decode
    ////////////////////////////////////////////////////////////////////////////

    assign accept_branch = branch_i && !stall_i;

    // Held instruction leaves on any unstalled edge
    // A branch wins over a normal step
    assign step = fetch_ready_i && !stall_i && !branch_i;

    assign word_cnt_inc = word_cnt + 30'd1;
    assign fetch_addr_o = word_cnt;

    // Second half of a split instruction arrives one word after its start
    assign pc_word = (align_long && align_high) ? word_cnt - 30'd1 : word_cnt;

    instr_aligner i_align (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .step_i          (step),
        .redirect_i      (accept_branch),
        .redirect_high_i (branch_pc_i[0]),
        .word_i          (fetch_data_i),
        .instr_o         (align_instr),
        .is_long_o       (align_long),
        .complete_o      (align_complete),
        .word_done_o     (align_word_done),
        .high_o          (align_high)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Word counter and control flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            word_cnt      <= ifu_pkg::RESET_PC[30:1];
            instr_valid_o <= 1'b0;
            busywait_o    <= 1'b0;
        end else begin
            // Only the cycle right after the redirect
            busywait_o <= accept_branch;

            if (accept_branch) begin
                word_cnt      <= branch_pc_i[30:1];
                instr_valid_o <= 1'b0;
            end else if (!stall_i) begin
                if (fetch_ready_i) begin
                    instr_valid_o <= align_complete;
                    if (align_word_done) begin
                        word_cnt <= word_cnt_inc;
                    end
                end else begin
                    // Old instruction was taken, nothing new yet
                    instr_valid_o <= 1'b0;
                end
            end
        end
    end

    // Decode payload, qualified by instr_valid_o
    always_ff @(posedge clk_i) begin
        if (step) begin
            instr_o   <= align_instr;
            is_long_o <= align_long;
            pc_o      <= {pc_word, align_high};
        end
    end

endmodule

// File: ifetch/instr_aligner.sv
`timescale 1ns/1ps

module instr_aligner (
    input  logic            clk_i,
    input  logic            rst_i,

    input  logic            step_i,
    input  logic            redirect_i,
    input  logic            redirect_high_i,
    input  ifu_pkg::word_t  word_i,

    output ifu_pkg::word_t  instr_o,
    output logic            is_long_o,
    output logic            complete_o,
    output logic            word_done_o,
    output logic            high_o
);

    ifu_pkg::align_state_e state;
    ifu_pkg::align_state_e state_next;

    ifu_pkg::half_t        held_half;
    ifu_pkg::half_t        lo_half;
    ifu_pkg::half_t        hi_half;

    logic                  lo_long;
    logic                  hi_long;
    logic                  hold_hi;

    assign lo_half = word_i[15:0];
    assign hi_half = word_i[31:16];

    // Length test, only meaningful for a half that starts an instruction
    assign lo_long = (lo_half[1:0] == ifu_pkg::LONG_OPCODE);
    assign hi_long = (hi_half[1:0] == ifu_pkg::LONG_OPCODE);

    // A split instruction still counts as starting in the upper half
    assign high_o = (state != ifu_pkg::LOW);

    ////////////////////////////////////////////////////////////////////////////
    // Length decision and assembly
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        instr_o     = {16'h0000, lo_half};
        is_long_o   = 1'b0;
        complete_o  = 1'b0;
        word_done_o = 1'b0;
        hold_hi     = 1'b0;
        state_next  = state;

        case (state)
            ifu_pkg::LOW: begin
                complete_o = 1'b1;
                if (lo_long) begin
                    // Whole word is one instruction
                    instr_o     = word_i;
                    is_long_o   = 1'b1;
                    word_done_o = 1'b1;
                    state_next  = ifu_pkg::LOW;
                end else begin
                    instr_o    = {16'h0000, lo_half};
                    state_next = ifu_pkg::HIGH;
                end
            end

            ifu_pkg::HIGH: begin
                word_done_o = 1'b1;
                instr_o     = {16'h0000, hi_half};
                if (hi_long) begin
                    // First half only, wait for the next word
                    is_long_o  = 1'b1;
                    hold_hi    = 1'b1;
                    state_next = ifu_pkg::SPLIT;
                end else begin
                    complete_o = 1'b1;
                    state_next = ifu_pkg::LOW;
                end
            end

            ifu_pkg::SPLIT: begin
                // Low half here is a tail, no length test on it
                instr_o    = {lo_half, held_half};
                is_long_o  = 1'b1;
                complete_o = 1'b1;
                state_next = ifu_pkg::HIGH;
            end

            default: begin
                state_next = ifu_pkg::LOW;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // State and held half
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state <= ifu_pkg::LOW;
        end else if (redirect_i) begin
            // Leaving SPLIT drops any held half
            state <= redirect_high_i ? ifu_pkg::HIGH : ifu_pkg::LOW;
        end else if (step_i) begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_i && hold_hi) begin
            held_half <= hi_half;
        end
    end

endmodule

// File: verification/ifetch_tb.sv
`timescale 1ns/1ps

module ifetch_tb;

    localparam int WAIT_LIMIT = 100;

    logic            clk;
    logic            rst;
    logic            stall;
    logic            branch;
    ifu_pkg::pc_t    branch_pc;
    ifu_pkg::word_t  instr;
    logic            is_long;
    ifu_pkg::pc_t    pc;
    logic            instr_valid;
    logic            busywait;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    ifu_pkg::waddr_t wb_adr;
    ifu_pkg::word_t  wb_dat;
    logic            wb_ack;

    int              errors;
    logic [31:0]     seed;

    // Stimulus and expected values, one entry per row
    logic            row_stall[$];
    logic            row_branch[$];
    ifu_pkg::pc_t    row_target[$];
    ifu_pkg::pc_t    row_pc[$];
    ifu_pkg::word_t  row_instr[$];
    logic            row_long[$];

    ifetch_top i_ifetch_top (
        .clk_i(clk), .rst_i(rst), .stall_i(stall), .branch_i(branch),
        .branch_pc_i(branch_pc), .instr_o(instr), .is_long_o(is_long), .pc_o(pc),
        .instr_valid_o(instr_valid), .busywait_o(busywait), .wb_cyc_o(wb_cyc),
        .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_i(wb_dat),
        .wb_ack_i(wb_ack)
    );

    wb_rom_model i_rom (
        .clk_i(clk), .rst_i(rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_pc(input string name, input ifu_pkg::pc_t got,
                            input ifu_pkg::pc_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_instr(input string name, input ifu_pkg::word_t got,
                               input ifu_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic st, input logic br, input ifu_pkg::pc_t tgt,
                           input ifu_pkg::pc_t epc, input ifu_pkg::word_t ei,
                           input logic el);
        row_stall.push_back(st);
        row_branch.push_back(br);
        row_target.push_back(tgt);
        row_pc.push_back(epc);
        row_instr.push_back(ei);
        row_long.push_back(el);
    endtask

    // Mixed 16 and 32 bit program, other words hold long fillers
    task automatic load_image();
        for (int k = 0; k < 64; k++) begin
            i_rom.mem[k] = {16'(k), 14'(k), 2'b11};
        end
        i_rom.mem[0]  = 32'h1111_2223;
        i_rom.mem[1]  = 32'h3333_4443;
        i_rom.mem[2]  = 32'h5555_6667;
        i_rom.mem[3]  = 32'hA5A1_4441;
        i_rom.mem[4]  = 32'hBEE3_1235;
        i_rom.mem[5]  = 32'h2221_C0DF;
        i_rom.mem[6]  = 32'h7777_8883;
        i_rom.mem[7]  = 32'hF00F_9991;
        i_rom.mem[8]  = 32'h5551_1357;
        i_rom.mem[9]  = 32'hABCD_0123;
        i_rom.mem[10] = 32'hCAF3_0001;
        i_rom.mem[11] = 32'h7001_BAB3;
        i_rom.mem[12] = 32'h0246_8ACB;
    endtask

    task automatic hold_under_stall();
        ifu_pkg::word_t snap_instr;
        ifu_pkg::pc_t   snap_pc;
        logic           snap_valid;
        logic           snap_long;
        int             cycles;
        seed       = next_rand(seed);
        cycles     = int'(seed[17:16]) + 1;
        stall      = 1'b1;
        snap_instr = instr;
        snap_pc    = pc;
        snap_valid = instr_valid;
        snap_long  = is_long;
        repeat (cycles) begin
            @(negedge clk);
            check_instr("instr_o", instr, snap_instr);
            check_pc("pc_o", pc, snap_pc);
            check_flag("instr_valid_o", instr_valid, snap_valid);
            check_flag("is_long_o", is_long, snap_long);
        end
        stall = 1'b0;
    endtask

    // Busywait lasts exactly the one cycle after the redirect
    task automatic apply_branch(input ifu_pkg::pc_t target);
        branch    = 1'b1;
        branch_pc = target;
        @(negedge clk);
        check_flag("busywait_o", busywait, 1'b1);
        check_flag("instr_valid_o", instr_valid, 1'b0);
        branch = 1'b0;
        @(negedge clk);
        check_flag("busywait_o", busywait, 1'b0);
    endtask

    task automatic wait_transfer(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (n < WAIT_LIMIT) begin
            if (instr_valid && !stall) begin
                ok = 1'b1;
                break;
            end
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        int  errs_before;
        bit  ok;
        bit  timed_out;
        int  rows_run;
        errors    = 0;
        timed_out = 1'b0;
        rows_run  = 0;
        seed      = 32'd78760;
        rst       = 1'b0;
        stall     = 1'b0;
        branch    = 1'b0;
        branch_pc = '0;
        load_image();

        add_row(1'b0, 1'b0, 31'd0,  ifu_pkg::RESET_PC, 32'h1111_2223, 1'b1);
        add_row(1'b1, 1'b0, 31'd0,  31'd2,  32'h3333_4443, 1'b1);
        add_row(1'b0, 1'b0, 31'd0,  31'd4,  32'h5555_6667, 1'b1);
        add_row(1'b0, 1'b0, 31'd0,  31'd6,  32'h0000_4441, 1'b0);
        add_row(1'b1, 1'b0, 31'd0,  31'd7,  32'h0000_A5A1, 1'b0);
        add_row(1'b0, 1'b0, 31'd0,  31'd8,  32'h0000_1235, 1'b0);
        add_row(1'b0, 1'b1, 31'd21, 31'd21, 32'hBAB3_CAF3, 1'b1);
        add_row(1'b0, 1'b0, 31'd0,  31'd23, 32'h0000_7001, 1'b0);
        add_row(1'b1, 1'b0, 31'd0,  31'd24, 32'h0246_8ACB, 1'b1);
        add_row(1'b0, 1'b1, 31'd7,  31'd7,  32'h0000_A5A1, 1'b0);
        add_row(1'b1, 1'b0, 31'd0,  31'd8,  32'h0000_1235, 1'b0);
        add_row(1'b0, 1'b0, 31'd0,  31'd9,  32'hC0DF_BEE3, 1'b1);
        add_row(1'b1, 1'b0, 31'd0,  31'd11, 32'h0000_2221, 1'b0);
        add_row(1'b0, 1'b0, 31'd0,  31'd12, 32'h7777_8883, 1'b1);
        add_row(1'b1, 1'b0, 31'd0,  31'd14, 32'h0000_9991, 1'b0);
        add_row(1'b0, 1'b0, 31'd0,  31'd15, 32'h1357_F00F, 1'b1);
        add_row(1'b1, 1'b0, 31'd0,  31'd17, 32'h0000_5551, 1'b0);
        add_row(1'b0, 1'b0, 31'd0,  31'd18, 32'hABCD_0123, 1'b1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("instr_valid_o", instr_valid, 1'b0);
        check_flag("wb_cyc_o", wb_cyc, 1'b0);
        check_flag("wb_stb_o", wb_stb, 1'b0);
        check_flag("wb_we_o", wb_we, 1'b0);
        check_flag("busywait_o", busywait, 1'b0);
        rst = 1'b1;

        ////////////////////////////////////////////////////////////////////////
        // Row loop
        ////////////////////////////////////////////////////////////////////////
        for (int r = 0; r < row_pc.size(); r++) begin
            errs_before = errors;
            if (row_branch[r]) begin
                apply_branch(row_target[r]);
            end else if (row_stall[r]) begin
                hold_under_stall();
            end
            wait_transfer(ok);
            if (!ok) begin
                timed_out = 1'b1;
                $display("row %0d: no instruction was transferred within %0d cycles",
                         r, WAIT_LIMIT);
                break;
            end
            check_pc("pc_o", pc, row_pc[r]);
            check_instr("instr_o", instr, row_instr[r]);
            check_flag("is_long_o", is_long, row_long[r]);
            @(posedge clk);
            @(negedge clk);
            rows_run++;
            $display("row %0d pc %0d %s", r, row_pc[r],
                     (errors == errs_before) ? "passed" : "failed");
        end

        $display("rows run %0d of %0d, errors %0d", rows_run, row_pc.size(), errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verification/wb_rom_model.sv
`timescale 1ns/1ps

module wb_rom_model #(
    parameter logic [31:0] SEED = 32'd78760
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  ifu_pkg::waddr_t  wb_adr_i,
    output ifu_pkg::word_t   wb_dat_o,
    output logic             wb_ack_o
);

    // Program image, filled by the testbench
    ifu_pkg::word_t mem [0:63];

    logic [31:0]    rand_state;
    logic [1:0]     wait_left;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Classic read with 0 to 3 wait states
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_ack_o   <= 1'b0;
            rand_state <= SEED;
            wait_left  <= SEED[17:16];
        end else if (wb_ack_o) begin
            // Single ack cycle, then pick the next delay
            wb_ack_o   <= 1'b0;
            rand_state <= next_rand(rand_state);
            wait_left  <= rand_state[17:16];
        end else if (wb_cyc_i && wb_stb_i && !wb_we_i) begin
            // A write request is never acknowledged
            if (wait_left == 2'd0) begin
                wb_ack_o <= 1'b1;
                wb_dat_o <= mem[wb_adr_i[5:0]];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

// File: verilog.f
common/ifu_pkg.sv
verilog/wb_fetch_port.sv
ifetch/instr_aligner.sv
ifetch/fetch_unit.sv
verilog/ifetch_top.sv
verification/wb_rom_model.sv
verification/ifetch_tb.sv

// File: verilog/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top (
    input  logic             clk_i,
    input  logic             rst_i,

    // Decode side
    input  logic             stall_i,
    input  logic             branch_i,
    input  ifu_pkg::pc_t     branch_pc_i,
    output ifu_pkg::word_t   instr_o,
    output logic             is_long_o,
    output ifu_pkg::pc_t     pc_o,
    output logic             instr_valid_o,
    output logic             busywait_o,

    // Wishbone master
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic             wb_we_o,
    output ifu_pkg::waddr_t  wb_adr_o,
    input  ifu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i
);

    ifu_pkg::waddr_t fetch_addr;
    ifu_pkg::word_t  fetch_data;
    logic            fetch_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////

    wb_fetch_port i_port (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_addr_i  (fetch_addr),
        .fetch_data_o  (fetch_data),
        .fetch_ready_o (fetch_ready),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and alignment
    ////////////////////////////////////////////////////////////////////////////

    fetch_unit i_fetch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .branch_i      (branch_i),
        .branch_pc_i   (branch_pc_i),
        .fetch_data_i  (fetch_data),
        .fetch_ready_i (fetch_ready),
        .fetch_addr_o  (fetch_addr),
        .instr_o       (instr_o),
        .is_long_o     (is_long_o),
        .pc_o          (pc_o),
        .instr_valid_o (instr_valid_o),
        .busywait_o    (busywait_o)
    );

endmodule

// File: verilog/wb_fetch_port.sv
`timescale 1ns/1ps

module wb_fetch_port (
    input  logic             clk_i,
    input  logic             rst_i,

    input  ifu_pkg::waddr_t  fetch_addr_i,
    output ifu_pkg::word_t   fetch_data_o,
    output logic             fetch_ready_o,

    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic             wb_we_o,
    output ifu_pkg::waddr_t  wb_adr_o,
    input  ifu_pkg::word_t   wb_dat_i,
    input  logic             wb_ack_i
);

    ifu_pkg::wb_state_e state;

    logic               buf_valid;
    ifu_pkg::waddr_t    buf_tag;
    ifu_pkg::word_t     buf_data;
    logic               hit;

    ////////////////////////////////////////////////////////////////////////////
    // One-word buffer lookup
    ////////////////////////////////////////////////////////////////////////////

    assign hit           = buf_valid && (buf_tag == fetch_addr_i);
    assign fetch_ready_o = hit;
    assign fetch_data_o  = buf_data;

    // Classic read, strobe follows cycle
    assign wb_cyc_o = (state == ifu_pkg::BUS);
    assign wb_stb_o = (state == ifu_pkg::BUS);
    assign wb_we_o  = 1'b0;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state     <= ifu_pkg::IDLE;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                ifu_pkg::IDLE: begin
                    if (!hit) begin
                        state <= ifu_pkg::BUS;
                    end
                end

                ifu_pkg::BUS: begin
                    // Finish even if the fetch address moved meanwhile
                    if (wb_ack_i) begin
                        state     <= ifu_pkg::IDLE;
                        buf_valid <= 1'b1;
                    end
                end

                default: begin
                    state <= ifu_pkg::IDLE;
                end
            endcase
        end
    end

    // Address held for the whole cycle, buffer written on ack
    always_ff @(posedge clk_i) begin
        if (state == ifu_pkg::IDLE && !hit) begin
            wb_adr_o <= fetch_addr_i;
        end
        if (state == ifu_pkg::BUS && wb_ack_i) begin
            buf_tag  <= wb_adr_o;
            buf_data <= wb_dat_i;
        end
    end

endmodule
